/* sources.f */
+incdir+rtl
+incdir+tests
rtl/gfx_bus_pkg.sv
rtl/gfx_arb_pkg.sv
rtl/gfx_memory_arbiter.sv
rtl/gfx_memory_bank.sv
rtl/gfx_memory_subsystem.sv
tests/gfx_memory_tb.sv

/* Makefile */
# Verilator build and run of the graphics memory testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= gfx_memory_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/gfx_memory_vectors.svh */
`ifndef GFX_MEMORY_VECTORS_SVH
`define GFX_MEMORY_VECTORS_SVH

// one row per test, entries in order sprite, bg, overlay
// entry is {valid, delay from row start, address, completion rank within its bank}

localparam int NUM_ROWS = 15;

row_t vectors [NUM_ROWS] = '{
	// lone requests, all four bank selects
	{{1'b1, 2'd0, 16'h0123, 2'd0}, 21'h0, 21'h0},
	{21'h0, {1'b1, 2'd0, 16'h4567, 2'd0}, 21'h0},
	{21'h0, 21'h0, {1'b1, 2'd0, 16'h89ab, 2'd0}},
	{{1'b1, 2'd0, 16'hc0de, 2'd0}, 21'h0, 21'h0},
	{21'h0, 21'h0, {1'b1, 2'd0, 16'hffff, 2'd0}},
	// three banks at once
	{{1'b1, 2'd0, 16'h1000, 2'd0}, {1'b1, 2'd0, 16'h5000, 2'd0}, {1'b1, 2'd0, 16'hd000, 2'd0}},
	{{1'b1, 2'd0, 16'h4123, 2'd0}, {1'b1, 2'd0, 16'h8123, 2'd0}, {1'b1, 2'd0, 16'hc123, 2'd0}},
	// one bank, fixed priority
	{{1'b1, 2'd0, 16'h8001, 2'd0}, {1'b1, 2'd0, 16'h8002, 2'd1}, {1'b1, 2'd0, 16'h8003, 2'd2}},
	{{1'b1, 2'd0, 16'h0007, 2'd0}, {1'b1, 2'd0, 16'h0008, 2'd1}, {1'b1, 2'd0, 16'h4007, 2'd0}},
	// locked grant, late higher client waits
	{{1'b1, 2'd1, 16'h4200, 2'd1}, 21'h0, {1'b1, 2'd0, 16'h4100, 2'd0}},
	{{1'b1, 2'd1, 16'hc200, 2'd1}, {1'b1, 2'd0, 16'hc100, 2'd0}, {1'b1, 2'd1, 16'hc300, 2'd2}},
	// back to back from sprite on bank 0
	{{1'b1, 2'd0, 16'h2000, 2'd0}, 21'h0, 21'h0},
	{{1'b1, 2'd0, 16'h2001, 2'd0}, 21'h0, 21'h0},
	{{1'b1, 2'd0, 16'h2002, 2'd0}, 21'h0, 21'h0},
	{{1'b1, 2'd0, 16'h2003, 2'd0}, 21'h0, 21'h0}
};

`endif

/* tests/gfx_memory_tb.sv */
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_memory_tb;

	import gfx_bus_pkg::*;

	localparam int NC = `GFX_NUM_CLIENTS;

	typedef logic [`GFX_DATA_W-1:0] word_t;

	typedef struct packed {
		logic                   valid;
		logic [1:0]             delay; // cycles after row start
		logic [`GFX_ADDR_W-1:0] addr;
		logic [1:0]             rank;  // completion position in its bank
	} cli_vec_t;

	typedef cli_vec_t [0:NC-1] row_t; // 0 sprite, 1 bg, 2 overlay

	`include "gfx_memory_vectors.svh"

	logic    clk;
	logic    rst;
	rd_req_t req [NC];
	rd_rsp_t rsp [NC];
	load_t   load;

	word_t         ref_mem [logic [`GFX_ADDR_W-1:0]];
	int            cyc;
	int            n_mismatch;
	int            n_other;
	logic [NC-1:0] last_rdy;

	gfx_memory_subsystem i_gfx_memory_subsystem (
		.clk        (clk),
		.rst        (rst),
		.sprite_req (req[0]),
		.sprite_rsp (rsp[0]),
		.bg_req     (req[1]),
		.bg_rsp     (rsp[1]),
		.ov_req     (req[2]),
		.ov_rsp     (rsp[2]),
		.load       (load)
	);

	always #20 clk = ~clk;

	// ##################################################
	// watchdog
	localparam int WD_CYCLES = 8 + 4 + NUM_ROWS * (NC + 20);

	initial begin
		#(WD_CYCLES * 40);
		$display("timeout: run did not finish within %0d cycles", WD_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic step();
		@(posedge clk);
		#2; // inputs change just after the edge
		cyc++;
	endtask

	task automatic check_ready_low(input string phase);
		for (int c = 0; c < NC; c++) begin
			if (rsp[c].ready !== 1'b0) begin
				$display("mismatch at %0t: client %0d ready high %s", $time, c, phase);
				n_mismatch++;
			end
		end
	endtask

	// random word for every address in the table, written through the load port
	task automatic load_refs();
		logic [`GFX_ADDR_W-1:0] a;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NC; c++) begin
				a = vectors[r][c].addr;
				if (vectors[r][c].valid && !ref_mem.exists(a)) begin
					ref_mem[a] = word_t'($urandom);
					load.en    = 1'b1;
					load.addr  = a;
					load.data  = ref_mem[a];
					step();
				end
			end
		end
		load.en = 1'b0;
		step();
	endtask

	// bank grants by rank, one cycle to ready, free again the cycle after
	function automatic int expected_done(input row_t row, input int c);
		int bank;
		int prev_done;
		int grant;
		bank      = int'(row[c].addr[`GFX_ADDR_W-1:`GFX_BANK_ADDR_W]);
		prev_done = -2;
		for (int r = 0; r <= int'(row[c].rank); r++) begin
			for (int k = 0; k < NC; k++) begin
				if (row[k].valid && int'(row[k].rank) == r &&
						int'(row[k].addr[`GFX_ADDR_W-1:`GFX_BANK_ADDR_W]) == bank) begin
					grant     = (int'(row[k].delay) > prev_done + 1) ?
						int'(row[k].delay) : prev_done + 1;
					prev_done = grant + 1;
				end
			end
		end
		return prev_done;
	endfunction

	task automatic run_row(input int r);
		row_t row;
		int   exp_done [NC];
		int   done_t   [NC];
		int   pending;
		int   t;
		row     = vectors[r];
		pending = 0;
		for (int c = 0; c < NC; c++) begin
			exp_done[c] = expected_done(row, c);
			done_t[c]   = -1;
			if (row[c].valid)
				pending++;
		end
		t = 0;
		forever begin
			for (int c = 0; c < NC; c++) begin
				if (rsp[c].ready) begin
					if (last_rdy[c]) begin
						$display("row %0d: client %0d ready held for two cycles", r, c);
						n_other++;
					end
					if (!row[c].valid || t <= int'(row[c].delay) || done_t[c] >= 0) begin
						$display("row %0d: client %0d got ready with no open request", r, c);
						n_other++;
					end else begin
						done_t[c] = t;
						pending--;
						if (rsp[c].data !== ref_mem[row[c].addr]) begin
							$display("mismatch at %0t: row %0d client %0d data %h expected %h",
								$time, r, c, rsp[c].data, ref_mem[row[c].addr]);
							n_mismatch++;
						end
						if (t != exp_done[c]) begin
							$display("mismatch at %0t: row %0d client %0d done at %0d expected %0d",
								$time, r, c, t, exp_done[c]);
							n_mismatch++;
						end
					end
				end
				last_rdy[c] = rsp[c].ready;
			end

			// hold valid through the ready cycle, drop it after
			for (int c = 0; c < NC; c++) begin
				req[c].valid = row[c].valid && t >= int'(row[c].delay) &&
					(done_t[c] < 0 || done_t[c] == t);
				req[c].addr  = row[c].addr;
			end

			if (pending == 0)
				break;
			step();
			t++;
		end
		step(); // end of the last ready cycle
	endtask

	// ##################################################
	// main sequence
	initial begin
		void'($urandom(15278));
		clk        = 1'b0;
		rst        = 1'b1;
		cyc        = 0;
		n_mismatch = 0;
		n_other    = 0;
		last_rdy   = '0;
		load       = '0;
		for (int c = 0; c < NC; c++)
			req[c] = '0;
		req[0].valid = 1'b1; // must not be served while in reset
		req[0].addr  = 16'h0123;

		repeat (8) begin
			step();
			check_ready_low("during reset");
		end
		req[0].valid = 1'b0;
		rst          = 1'b0;
		repeat (2) begin
			step();
			check_ready_low("after reset");
		end

		load_refs();

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		for (int c = 0; c < NC; c++)
			req[c].valid = 1'b0;
		step();

		$display("errors: %0d mismatches, %0d other, %0d cycles", n_mismatch, n_other, cyc);
		if (n_mismatch + n_other == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* rtl/gfx_memory_subsystem.sv */
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_memory_subsystem (
	input  logic                 clk,
	input  logic                 rst,

	input  gfx_bus_pkg::rd_req_t sprite_req,
	output gfx_bus_pkg::rd_rsp_t sprite_rsp,

	input  gfx_bus_pkg::rd_req_t bg_req,
	output gfx_bus_pkg::rd_rsp_t bg_rsp,

	input  gfx_bus_pkg::rd_req_t ov_req,
	output gfx_bus_pkg::rd_rsp_t ov_rsp,

	input  gfx_bus_pkg::load_t   load
);

	import gfx_bus_pkg::*;
	import gfx_arb_pkg::*;

	rd_req_t   client_req [`GFX_NUM_CLIENTS];
	rd_rsp_t   client_rsp [`GFX_NUM_CLIENTS];
	bank_req_t bank_req   [`GFX_NUM_BANKS];
	bank_rsp_t bank_rsp   [`GFX_NUM_BANKS];

	// slot index is the priority
	assign client_req[client_sprite] = sprite_req;
	assign client_req[client_bg]     = bg_req;
	assign client_req[client_ov]     = ov_req;

	assign sprite_rsp = client_rsp[client_sprite];
	assign bg_rsp     = client_rsp[client_bg];
	assign ov_rsp     = client_rsp[client_ov];

	gfx_memory_arbiter i_arbiter (
		.clk        (clk),
		.rst        (rst),
		.client_req (client_req),
		.client_rsp (client_rsp),
		.bank_req   (bank_req),
		.bank_rsp   (bank_rsp)
	);

	for (genvar b = 0; b < `GFX_NUM_BANKS; b++) begin : g_bank
		gfx_memory_bank #(
			.BANK_ID (b)
		) i_bank (
			.clk  (clk),
			.rst  (rst),
			.req  (bank_req[b]),
			.rsp  (bank_rsp[b]),
			.load (load)   // every bank snoops, decodes its own
		);
	end

endmodule

/* rtl/gfx_memory_bank.sv */
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_memory_bank #(
	parameter int BANK_ID = 0
) (
	input  logic                   clk,
	input  logic                   rst,

	input  gfx_bus_pkg::bank_req_t req,
	output gfx_bus_pkg::bank_rsp_t rsp,

	input  gfx_bus_pkg::load_t     load
);

	localparam int DEPTH = 2 ** `GFX_BANK_ADDR_W;

	logic [`GFX_DATA_W-1:0] mem [DEPTH];

	logic                   ready_q;
	logic [`GFX_DATA_W-1:0] dout_q;
	logic                   accept;
	logic                   load_hit;

	assign accept   = req.valid && !ready_q; // no accept while pulsing
	assign load_hit = load.en &&
		(load.addr[`GFX_ADDR_W-1:`GFX_BANK_ADDR_W] == BANK_ID);

	// ##################################################
	// storage
	always_ff @(posedge clk) begin
		if (load_hit)
			mem[load.addr[`GFX_BANK_ADDR_W-1:0]] <= load.data;
		if (accept)
			dout_q <= mem[req.addr];
	end

	always_ff @(posedge clk) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= accept; // one cycle after acceptance
	end

	assign rsp.ready = ready_q;
	assign rsp.dout  = dout_q;

	// a request during the ready pulse would be dropped
	a_no_lost_req: assert property (@(posedge clk) disable iff (rst)
		rsp.ready |-> !req.valid)
		else $error("bank %0d request during ready pulse not accepted", BANK_ID);

endmodule

/* rtl/gfx_memory_arbiter.sv */
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_memory_arbiter (
	input  logic                 clk,
	input  logic                 rst,

	input  gfx_bus_pkg::rd_req_t   client_req [`GFX_NUM_CLIENTS],
	output gfx_bus_pkg::rd_rsp_t   client_rsp [`GFX_NUM_CLIENTS],

	output gfx_bus_pkg::bank_req_t bank_req [`GFX_NUM_BANKS],
	input  gfx_bus_pkg::bank_rsp_t bank_rsp [`GFX_NUM_BANKS]
);

	import gfx_arb_pkg::*;

	localparam int NB = `GFX_NUM_BANKS;
	localparam int NC = `GFX_NUM_CLIENTS;

	grant_state_e state_q [NB];
	client_e      owner_q [NB];

	logic [NC-1:0] hit       [NB]; // client wants this bank
	client_e       new_owner [NB];
	client_e       cur_owner [NB];
	logic          cur_active [NB];
	logic [NB-1:0] routed    [NC]; // per client, banks it is routed to

	// ##################################################
	// selection and request routing
	always_comb begin
		for (int b = 0; b < NB; b++) begin
			for (int c = 0; c < NC; c++) begin
				hit[b][c] = client_req[c].valid &&
					(client_req[c].addr[`GFX_ADDR_W-1:`GFX_BANK_ADDR_W] == b);
			end

			// walk down so the lowest index is left
			new_owner[b] = client_sprite;
			for (int c = NC - 1; c >= 0; c--) begin
				if (hit[b][c])
					new_owner[b] = client_e'(c);
			end

			if (state_q[b] == grant_idle) begin
				cur_owner[b]  = new_owner[b];
				cur_active[b] = |hit[b];
			end else begin
				cur_owner[b]  = owner_q[b];
				cur_active[b] = 1'b1;
			end

			// bank only sees valid on a fresh grant, it already holds the read otherwise
			bank_req[b].valid = (state_q[b] == grant_idle) && |hit[b];
			bank_req[b].addr  = client_req[cur_owner[b]].addr[`GFX_BANK_ADDR_W-1:0];
		end

		for (int c = 0; c < NC; c++) begin
			for (int b = 0; b < NB; b++)
				routed[c][b] = cur_active[b] && (cur_owner[b] == client_e'(c));
		end
	end

	// ##################################################
	// return path
	always_comb begin
		for (int c = 0; c < NC; c++) begin
			client_rsp[c] = '0;
			for (int b = 0; b < NB; b++) begin
				if (state_q[b] == grant_owned && owner_q[b] == client_e'(c) &&
						bank_rsp[b].ready) begin
					client_rsp[c].ready = 1'b1;
					client_rsp[c].data  = bank_rsp[b].dout;
				end
			end
		end
	end

	// ##################################################
	// grant state
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < NB; b++) begin
				state_q[b] <= grant_idle;
				owner_q[b] <= client_sprite;
			end
		end else begin
			for (int b = 0; b < NB; b++) begin
				case (state_q[b])
					grant_idle: begin
						if (|hit[b]) begin
							state_q[b] <= grant_owned;
							owner_q[b] <= new_owner[b];
						end
					end
					grant_owned: begin
						if (bank_rsp[b].ready)
							state_q[b] <= grant_idle; // read done, release
					end
					default: state_q[b] <= grant_idle;
				endcase
			end
		end
	end

	for (genvar c = 0; c < NC; c++) begin : g_chk
		// a held address maps to one bank, so ownership never spreads
		a_one_bank: assert property (@(posedge clk) disable iff (rst)
			$onehot0(routed[c]))
			else $error("client %0d routed to more than one bank", c);

		a_rdy_valid: assert property (@(posedge clk) disable iff (rst)
			client_rsp[c].ready |-> client_req[c].valid)
			else $error("ready to client %0d without valid", c);
	end

endmodule

/* rtl/gfx_arb_pkg.sv */
`include "gfx_macros.svh"

package gfx_arb_pkg;

	// numeric order is the priority order, lowest wins
	typedef enum logic [$clog2(`GFX_NUM_CLIENTS)-1:0] {
		client_sprite = 0,
		client_bg     = 1,
		client_ov     = 2
	} client_e;

	// per-bank grant
	typedef enum logic {
		grant_idle  = 1'b0,
		grant_owned = 1'b1  // locked until bank ready
	} grant_state_e;

endpackage

/* rtl/gfx_bus_pkg.sv */
`include "gfx_macros.svh"

package gfx_bus_pkg;

	// ##################################################
	// client side
	typedef struct packed {
		logic                   valid; // address valid level
		logic [`GFX_ADDR_W-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic                   ready; // one-cycle data pulse
		logic [`GFX_DATA_W-1:0] data;
	} rd_rsp_t;

	// ##################################################
	// bank side
	typedef struct packed {
		logic                        valid;
		logic [`GFX_BANK_ADDR_W-1:0] addr;
	} bank_req_t;

	typedef struct packed {
		logic                   ready;
		logic [`GFX_DATA_W-1:0] dout;
	} bank_rsp_t;

	// preload port, full client address
	typedef struct packed {
		logic                   en;
		logic [`GFX_ADDR_W-1:0] addr;
		logic [`GFX_DATA_W-1:0] data;
	} load_t;

endpackage

/* rtl/gfx_macros.svh */
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// client side address and data
`define GFX_ADDR_W       16
`define GFX_DATA_W       16

// word address inside one bank
`define GFX_BANK_ADDR_W  14

`define GFX_NUM_BANKS    4
`define GFX_NUM_CLIENTS  3 // sprite, bg, overlay

`endif
